/* compile.f */
+incdir+testbench
logic/cpu_pkg.sv
logic/ctrl_if.sv
logic/alu.sv
logic/register_file.sv
logic/next_pc_logic.sv
logic/control_unit.sv
logic/datapath.sv
logic/cpu_top.sv
testbench/tb_cpu_top.sv

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_t op,
    output cpu_pkg::word_t   result
);
    import cpu_pkg::*;

    always_comb begin
        case (op)
            FUNC_ADD: result = a + b;                 // wraps at 16 bits
            FUNC_SUB: result = a - b;
            FUNC_AND: result = a & b;
            FUNC_ORR: result = a | b;
            FUNC_NOT: result = ~a;
            FUNC_TCP: result = ~a + word_t'(1);       // negate
            FUNC_SHL: result = {a[WORD_SIZE-2:0], 1'b0};
            FUNC_SHR: result = {a[WORD_SIZE-1], a[WORD_SIZE-1:1]}; // keeps sign
            default:  result = a + b;
        endcase
    end

endmodule

/* logic/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  cpu_pkg::word_t instr,
    ctrl_if.decoder        ctrl
);
    import cpu_pkg::*;

    opcode_t opcode;
    func_t   func;

    assign opcode = instr[15:12];
    assign func   = instr[5:0];

    always_comb begin
        // no-operation unless decoded below
        ctrl.alu_src     = 1'b0;
        ctrl.alu_op      = FUNC_ADD;
        ctrl.imm_kind    = IMM_SIGN;
        ctrl.reg_write   = 1'b0;
        ctrl.reg_dst     = DST_RD;
        ctrl.mem_read    = 1'b0;
        ctrl.mem_write   = 1'b0;
        ctrl.mem_to_reg  = 1'b0;
        ctrl.pc_to_reg   = 1'b0;
        ctrl.branch      = 1'b0;
        ctrl.branch_kind = BR_NE;
        ctrl.jump_kind   = JUMP_NONE;

        case (opcode)
            ALU_OP: begin
                case (func)
                    INST_FUNC_ADD, INST_FUNC_SUB, INST_FUNC_AND, INST_FUNC_ORR,
                    INST_FUNC_NOT, INST_FUNC_TCP, INST_FUNC_SHL, INST_FUNC_SHR: begin
                        ctrl.alu_op    = alu_op_t'(func[2:0]); // same low bits
                        ctrl.reg_write = 1'b1;
                    end
                    INST_FUNC_JPR: ctrl.jump_kind = JUMP_REG;
                    INST_FUNC_JRL: begin
                        ctrl.jump_kind = JUMP_REG;
                        ctrl.pc_to_reg = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.reg_dst   = DST_LINK;
                    end
                    default: ; // unknown function code
                endcase
            end
            ADI_OP, ORI_OP, LHI_OP: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = DST_RT;
                if (opcode == ORI_OP) begin
                    ctrl.imm_kind = IMM_ZERO;
                    ctrl.alu_op   = FUNC_ORR;
                end else if (opcode == LHI_OP) begin
                    ctrl.imm_kind = IMM_UPPER; // 0 | imm << 8
                    ctrl.alu_op   = FUNC_ORR;
                end
            end
            LWD_OP: begin
                ctrl.alu_src    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = DST_RT;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            SWD_OP: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            BNE_OP, BEQ_OP, BGZ_OP, BLZ_OP: begin
                ctrl.branch      = 1'b1;
                ctrl.alu_op      = FUNC_SUB;
                ctrl.branch_kind = branch_kind_t'(opcode[1:0]);
            end
            JMP_OP: ctrl.jump_kind = JUMP_TARGET;
            JAL_OP: begin
                ctrl.jump_kind = JUMP_TARGET;
                ctrl.pc_to_reg = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = DST_LINK;
            end
            default: ; // unknown opcode
        endcase
    end

endmodule

/* logic/cpu_pkg.sv */
package cpu_pkg;

    localparam int unsigned WORD_SIZE = 16;

    // ------------------------------
    // word and field types
    // ------------------------------
    typedef logic [WORD_SIZE-1:0] word_t;   // data, address or instruction
    typedef logic [3:0]           opcode_t; // instr[15:12]
    typedef logic [5:0]           func_t;   // instr[5:0]
    typedef logic [1:0]           reg_addr_t;
    typedef logic [7:0]           imm_t;    // instr[7:0]
    typedef logic [11:0]          target_t; // instr[11:0]

    // ------------------------------
    // opcodes
    // ------------------------------
    localparam opcode_t BNE_OP = 4'd0;
    localparam opcode_t BEQ_OP = 4'd1;
    localparam opcode_t BGZ_OP = 4'd2;
    localparam opcode_t BLZ_OP = 4'd3;
    localparam opcode_t ADI_OP = 4'd4;
    localparam opcode_t ORI_OP = 4'd5;
    localparam opcode_t LHI_OP = 4'd6;
    localparam opcode_t LWD_OP = 4'd7;
    localparam opcode_t SWD_OP = 4'd8;
    localparam opcode_t JMP_OP = 4'd9;
    localparam opcode_t JAL_OP = 4'd10;
    localparam opcode_t ALU_OP = 4'd15;
    localparam opcode_t JPR_OP = ALU_OP; // told apart by function code
    localparam opcode_t JRL_OP = ALU_OP;

    // ------------------------------
    // instruction function codes
    // ------------------------------
    localparam func_t INST_FUNC_ADD = 6'd0;
    localparam func_t INST_FUNC_SUB = 6'd1;
    localparam func_t INST_FUNC_AND = 6'd2;
    localparam func_t INST_FUNC_ORR = 6'd3;
    localparam func_t INST_FUNC_NOT = 6'd4;
    localparam func_t INST_FUNC_TCP = 6'd5;
    localparam func_t INST_FUNC_SHL = 6'd6;
    localparam func_t INST_FUNC_SHR = 6'd7;
    localparam func_t INST_FUNC_JPR = 6'd25;
    localparam func_t INST_FUNC_JRL = 6'd26;

    // ------------------------------
    // control selectors
    // ------------------------------
    typedef enum logic [2:0] {
        FUNC_ADD = 3'd0,
        FUNC_SUB = 3'd1,
        FUNC_AND = 3'd2,
        FUNC_ORR = 3'd3,
        FUNC_NOT = 3'd4,
        FUNC_TCP = 3'd5,
        FUNC_SHL = 3'd6,
        FUNC_SHR = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {IMM_SIGN, IMM_ZERO, IMM_UPPER} imm_kind_t;
    typedef enum logic [1:0] {DST_RD, DST_RT, DST_LINK} reg_dst_t;
    typedef enum logic [1:0] {BR_NE, BR_EQ, BR_GZ, BR_LZ} branch_kind_t;
    typedef enum logic [1:0] {JUMP_NONE, JUMP_TARGET, JUMP_REG} jump_kind_t;

endpackage

/* logic/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  logic           clk,
    input  logic           rst_n,
    output cpu_pkg::word_t i_addr,
    input  cpu_pkg::word_t i_data,
    output cpu_pkg::word_t d_addr,
    output cpu_pkg::word_t d_wdata,
    input  cpu_pkg::word_t d_rdata,
    output logic           d_read,
    output logic           d_write
);
    import cpu_pkg::*;

    word_t instr;   // fetched word, decoded in the same cycle

    ctrl_if ctrl_bus ();

    control_unit control_unit_inst (
        .instr (instr),
        .ctrl  (ctrl_bus.decoder)
    );

    datapath #(
        .RESET_PC (RESET_PC)
    ) datapath_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrl_bus.exec),
        .instr   (instr),
        .i_data  (i_data),
        .i_addr  (i_addr),
        .d_addr  (d_addr),
        .d_wdata (d_wdata),
        .d_rdata (d_rdata),
        .d_read  (d_read),
        .d_write (d_write)
    );

endmodule

/* logic/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if;
    import cpu_pkg::*;

    logic         alu_src;     // operand b from immediate
    alu_op_t      alu_op;
    imm_kind_t    imm_kind;
    logic         reg_write;
    reg_dst_t     reg_dst;
    logic         mem_read;
    logic         mem_write;
    logic         mem_to_reg;
    logic         pc_to_reg;   // link pc + 1
    logic         branch;
    branch_kind_t branch_kind;
    jump_kind_t   jump_kind;

    modport decoder (
        output alu_src, alu_op, imm_kind, reg_write, reg_dst,
        output mem_read, mem_write, mem_to_reg, pc_to_reg,
        output branch, branch_kind, jump_kind
    );

    modport exec (
        input alu_src, alu_op, imm_kind, reg_write, reg_dst,
        input mem_read, mem_write, mem_to_reg, pc_to_reg,
        input branch, branch_kind, jump_kind
    );

endinterface

/* logic/datapath.sv */
`timescale 1ns/1ps

module datapath #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  logic           clk,
    input  logic           rst_n,
    ctrl_if.exec           ctrl,
    output cpu_pkg::word_t instr,
    input  cpu_pkg::word_t i_data,
    output cpu_pkg::word_t i_addr,
    output cpu_pkg::word_t d_addr,
    output cpu_pkg::word_t d_wdata,
    input  cpu_pkg::word_t d_rdata,
    output logic           d_read,
    output logic           d_write
);
    import cpu_pkg::*;

    word_t     pc;
    word_t     next_pc;
    word_t     pc_plus_one;
    word_t     rs_data;
    word_t     rt_data;
    word_t     imm_ext;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    word_t     wr_data;
    reg_addr_t wr_addr;
    imm_t      imm;

    // ------------------------------
    // fetch
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    assign i_addr      = pc;
    assign instr       = i_data;
    assign pc_plus_one = pc + word_t'(1);
    assign imm         = instr[7:0];

    // ------------------------------
    // operands
    // ------------------------------
    always_comb begin
        case (ctrl.imm_kind)
            IMM_SIGN:  imm_ext = {{(WORD_SIZE-8){imm[7]}}, imm};
            IMM_UPPER: imm_ext = {imm, 8'h00};
            default:   imm_ext = {{(WORD_SIZE-8){1'b0}}, imm};
        endcase
    end

    assign alu_a = (ctrl.imm_kind == IMM_UPPER) ? '0 : rs_data; // lhi
    assign alu_b = ctrl.alu_src ? imm_ext : rt_data;

    // ------------------------------
    // writeback
    // ------------------------------
    always_comb begin
        case (ctrl.reg_dst)
            DST_RT:   wr_addr = instr[9:8];
            DST_LINK: wr_addr = 2'd2;
            default:  wr_addr = instr[7:6];
        endcase
    end

    assign wr_data = ctrl.pc_to_reg  ? pc_plus_one :
                     ctrl.mem_to_reg ? d_rdata     : alu_result;

    assign d_addr  = alu_result;
    assign d_wdata = rt_data;
    assign d_read  = ctrl.mem_read;
    assign d_write = ctrl.mem_write & rst_n; // no store while in reset

    register_file register_file_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (instr[11:10]),
        .rt_addr (instr[9:8]),
        .wr_addr (wr_addr),
        .wr_en   (ctrl.reg_write),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    alu alu_inst (
        .a      (alu_a),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result)
    );

    next_pc_logic next_pc_logic_inst (
        .pc      (pc),
        .instr   (instr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .ctrl    (ctrl),
        .next_pc (next_pc)
    );

endmodule

/* logic/next_pc_logic.sv */
`timescale 1ns/1ps

module next_pc_logic (
    input  cpu_pkg::word_t pc,
    input  cpu_pkg::word_t instr,
    input  cpu_pkg::word_t rs_data,
    input  cpu_pkg::word_t rt_data,
    ctrl_if.exec           ctrl,
    output cpu_pkg::word_t next_pc
);
    import cpu_pkg::*;

    word_t   pc_plus_one;
    word_t   branch_target;
    imm_t    offset;
    target_t target;
    logic    taken;

    assign offset        = instr[7:0];
    assign target        = instr[11:0];
    assign pc_plus_one   = pc + word_t'(1);
    assign branch_target = pc_plus_one + {{(WORD_SIZE-8){offset[7]}}, offset};

    always_comb begin
        case (ctrl.branch_kind)
            BR_NE:   taken = (rs_data != rt_data);
            BR_EQ:   taken = (rs_data == rt_data);
            BR_GZ:   taken = ($signed(rs_data) > $signed(word_t'(0)));
            BR_LZ:   taken = rs_data[WORD_SIZE-1];  // signed below zero
            default: taken = 1'b0;
        endcase
    end

    // jumps win over branches
    always_comb begin
        case (ctrl.jump_kind)
            JUMP_TARGET: next_pc = {pc[WORD_SIZE-1:12], target};
            JUMP_REG:    next_pc = rs_data;
            default:     next_pc = (ctrl.branch && taken) ? branch_target : pc_plus_one;
        endcase
    end

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  cpu_pkg::reg_addr_t wr_addr,
    input  logic               wr_en,
    input  cpu_pkg::word_t     wr_data,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data
);
    import cpu_pkg::*;

    localparam int unsigned NUM_REGS = 4;

    word_t regs [NUM_REGS];

    // reads see the value before this cycle's write
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

/* testbench/tb_cpu_model.svh */
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

// ------------------------------
// instruction-level reference model
// ------------------------------
word_t model_pc;
word_t model_regs [4];
word_t model_dmem [256];   // own copy of data memory

function automatic word_t sext8(input imm_t v);
    return {{8{v[7]}}, v};
endfunction

// runs one instruction, returns the memory port activity it should cause
task automatic execute_instr(
    input  word_t instr,
    output logic  exp_read,
    output logic  exp_write,
    output word_t exp_addr,
    output word_t exp_wdata
);
    word_t     a;
    word_t     b;
    word_t     link;
    word_t     next;
    reg_addr_t rt;
    reg_addr_t rd;
    imm_t      imm;

    a         = model_regs[instr[11:10]];
    b         = model_regs[instr[9:8]];
    rt        = instr[9:8];
    rd        = instr[7:6];
    imm       = instr[7:0];
    link      = model_pc + 16'd1;
    next      = link;
    exp_read  = 1'b0;
    exp_write = 1'b0;
    exp_addr  = a + sext8(imm);   // base plus offset for loads and stores
    exp_wdata = b;

    case (instr[15:12])
        ALU_OP: begin
            case (instr[5:0])
                INST_FUNC_ADD: model_regs[rd] = a + b;
                INST_FUNC_SUB: model_regs[rd] = a - b;
                INST_FUNC_AND: model_regs[rd] = a & b;
                INST_FUNC_ORR: model_regs[rd] = a | b;
                INST_FUNC_NOT: model_regs[rd] = ~a;
                INST_FUNC_TCP: model_regs[rd] = 16'd0 - a;
                INST_FUNC_SHL: model_regs[rd] = a << 1;
                INST_FUNC_SHR: model_regs[rd] = word_t'($signed(a) >>> 1);
                INST_FUNC_JPR: next = a;
                INST_FUNC_JRL: begin
                    next          = a;   // target read before the link write
                    model_regs[2] = link;
                end
                default: ;
            endcase
        end
        ADI_OP: model_regs[rt] = a + sext8(imm);
        ORI_OP: model_regs[rt] = a | {8'h00, imm};
        LHI_OP: model_regs[rt] = {imm, 8'h00};
        LWD_OP: begin
            exp_read       = 1'b1;
            model_regs[rt] = model_dmem[exp_addr[7:0]];
        end
        SWD_OP: begin
            exp_write                  = 1'b1;
            model_dmem[exp_addr[7:0]] = b;
        end
        BNE_OP: if (a != b) next = link + sext8(imm);
        BEQ_OP: if (a == b) next = link + sext8(imm);
        BGZ_OP: if ($signed(a) > 16'sd0) next = link + sext8(imm);
        BLZ_OP: if ($signed(a) < 16'sd0) next = link + sext8(imm);
        JMP_OP: next = {model_pc[15:12], instr[11:0]};
        JAL_OP: begin
            next          = {model_pc[15:12], instr[11:0]};
            model_regs[2] = link;
        end
        default: ;   // unused opcodes do nothing
    endcase
    model_pc = next;
endtask

`endif

/* testbench/tb_cpu_top.sv */
`timescale 1ns/1ps

module tb_cpu_top;
    import cpu_pkg::*;

    localparam int    CLK_PERIOD   = 4;
    localparam int    RESET_CYCLES = 3;
    localparam int    NUM_CYCLES   = 3000;
    localparam word_t RESET_PC     = 16'h0040;
    localparam int    WATCHDOG_NS  = (NUM_CYCLES + RESET_CYCLES + 10) * CLK_PERIOD;

    logic   clk;
    logic   rst_n;
    word_t  i_addr;
    word_t  i_data;
    word_t  d_addr;
    word_t  d_wdata;
    word_t  d_rdata;
    logic   d_read;
    logic   d_write;
    word_t  imem [256];
    word_t  dmem [256];
    integer seed;
    int     stores;
    logic   exp_read;
    logic   exp_write;
    word_t  exp_addr;
    word_t  exp_wdata;

    `include "tb_cpu_model.svh"

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) cpu_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_addr  (i_addr),
        .i_data  (i_data),
        .d_addr  (d_addr),
        .d_wdata (d_wdata),
        .d_rdata (d_rdata),
        .d_read  (d_read),
        .d_write (d_write)
    );

    assign i_data  = imem[i_addr[7:0]];   // combinational reads
    assign d_rdata = dmem[d_addr[7:0]];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // program generation and checks
    // ------------------------------
    function automatic word_t random_instr();
        word_t r;
        int    sel;
        func_t f;
        r   = $random(seed);
        sel = $unsigned($random(seed)) % 24;
        f   = r[5:0];
        if (f <= INST_FUNC_SHR || f == INST_FUNC_JPR || f == INST_FUNC_JRL) begin
            f = 6'd40;   // force an unused function code
        end
        case (sel)
            0, 1, 2, 3, 4, 5: return {ALU_OP, r[11:6], 3'b000, r[2:0]};
            6:       return {ADI_OP, r[11:0]};
            7:       return {ORI_OP, r[11:0]};
            8:       return {LHI_OP, r[11:0]};
            9, 10:   return {LWD_OP, r[11:0]};
            11, 12, 13: return {SWD_OP, r[11:0]};
            14:      return {BNE_OP, r[11:0]};
            15:      return {BEQ_OP, r[11:0]};
            16:      return {BGZ_OP, r[11:0]};
            17:      return {BLZ_OP, r[11:0]};
            18:      return {JMP_OP, r[11:0]};
            19:      return {JAL_OP, r[11:0]};
            20:      return {JPR_OP, r[11:6], INST_FUNC_JPR};
            21:      return {JRL_OP, r[11:6], INST_FUNC_JRL};
            22:      return {4'd11 + {2'b00, r[13:12]}, r[11:0]};   // opcodes 11 to 14
            default: return {ALU_OP, r[11:6], f};
        endcase
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_addr(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            stop_run($sformatf("Mismatch at %0t: %s is %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    task automatic check_data(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            stop_run($sformatf("Mismatch at %0t: %s is %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    task automatic check_strobe(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            stop_run($sformatf("Mismatch at %0t: %s is %b, expected %b",
                               $time, what, actual, expected));
        end
    endtask

    initial begin
        seed   = 32'h2cb1;
        stores = 0;
        rst_n  = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i]       = random_instr();
            dmem[i]       = $random(seed);
            model_dmem[i] = dmem[i];
        end
        // first word is a store that reset has to hold back
        imem[RESET_PC[7:0]] = {SWD_OP, imem[RESET_PC[7:0]][11:0]};
        for (int i = 0; i < 4; i++) begin
            model_regs[i] = '0;
        end
        model_pc = RESET_PC;

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_addr(i_addr, RESET_PC, "i_addr in reset");
            check_strobe(d_write, 1'b0, "d_write in reset");
        end
        rst_n = 1'b1;

        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(negedge clk);
            check_addr(i_addr, model_pc, "i_addr");
            execute_instr(imem[model_pc[7:0]], exp_read, exp_write, exp_addr, exp_wdata);
            check_strobe(d_read, exp_read, "d_read");
            check_strobe(d_write, exp_write, "d_write");
            if (exp_read || exp_write) begin
                check_addr(d_addr, exp_addr, "d_addr");
            end
            if (exp_write) begin
                check_data(d_wdata, exp_wdata, "d_wdata");
                stores++;
            end
            @(posedge clk);
            #1;
            if (exp_write) begin
                dmem[exp_addr[7:0]] = exp_wdata;   // store taken at the edge
            end
        end
        @(negedge clk);
        check_addr(i_addr, model_pc, "final i_addr");
        $display("%0d instructions run, %0d stores checked", NUM_CYCLES, stores);
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        stop_run("watchdog timeout: the run did not complete in the expected time");
    end

endmodule
